/* hdl/core_config.svh */
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// bridge command addresses
`define CORE_ADDR_RESET   32'hF0000000
`define CORE_ADDR_BOOT    32'hF1000000
`define CORE_ADDR_RUN     32'hF2000000

// core reset stretch, in clk_sys cycles
`define CORE_RESET_CYCLES 8000

// fast-forward tap window and button (right shoulder)
`define FF_TAP_CYCLES     256
`define FF_BUTTON_BIT     9

// video output shaping
`define HS_DELAY_CYCLES   7
`define BORDER_RGB        24'h002000

// four power-on colours in the top 96 bits
`define PALETTE_DEFAULT   128'h828214517356305A5F1A3B4900000000

`endif

/* hdl/core_pkg.sv */
`default_nettype none

package core_pkg;

  //////////////////////////////////////////////////
  // settings words written over the bridge
  //////////////////////////////////////////////////

  typedef struct packed {
    logic [29:0] spare;
    logic        gba_en;
    logic        sgb_en;
  } boot_settings_t;

  typedef struct packed {
    logic [24:0] spare;
    logic [1:0]  tint;
    logic        sgb_border_en;
    logic        ff_en;
    logic        ff_snd_en;
    logic        originalcolors;
    logic        rumble_en;
  } run_settings_t;

  // download slot ids as numbered by the host
  typedef enum logic [15:0] {
    slot_cart     = 16'd1,
    slot_border   = 16'd2,
    slot_palette  = 16'd3,
    slot_cgb_boot = 16'd4,
    slot_dmg_boot = 16'd5,
    slot_sgb_boot = 16'd6
  } slot_id_e;

  // fast-forward button states
  typedef enum logic [1:0] {
    ff_idle,
    ff_held,
    ff_latched,
    ff_latched_held
  } ff_state_e;

  //////////////////////////////////////////////////
  // video
  //////////////////////////////////////////////////

  // pixel stream from the lcd side
  typedef struct packed {
    logic [23:0] rgb;
    logic        hs;
    logic        vs;
    logic        hblank;
    logic        vblank;
  } core_pixel_t;

  // stream towards the scaler
  typedef struct packed {
    logic [23:0] rgb;
    logic        de;
    logic        hs;
    logic        vs;
  } video_out_t;

  // pal1 in [127:104] down to pal4 in [55:32], low word unused
  typedef logic [127:0] palette_t;

endpackage

`default_nettype wire

/* hdl/bridge_regs.sv */
`default_nettype none

`include "core_config.svh"

module bridge_regs
  import core_pkg::*;
(
  input  wire             clk_sys,
  input  wire             reset,
  input  wire  [31:0]     bridge_addr,
  input  wire             bridge_rd,
  input  wire             bridge_wr,
  input  wire  [31:0]     bridge_wr_data,
  output logic [31:0]     bridge_rd_data,
  output boot_settings_t  boot_settings,
  output run_settings_t   run_settings,
  output logic            reset_req
);

  logic hit_reset;
  logic hit_boot;
  logic hit_run;

  // address decode, shared by reads and writes
  assign hit_reset = (bridge_addr == `CORE_ADDR_RESET);
  assign hit_boot  = (bridge_addr == `CORE_ADDR_BOOT);
  assign hit_run   = (bridge_addr == `CORE_ADDR_RUN);

  always_ff @(posedge clk_sys) begin
    if (reset) begin
      boot_settings  <= '0;
      run_settings   <= '0;
      reset_req      <= 1'b0;
      bridge_rd_data <= '0;
    end else begin
      // a new boot word also restarts the core
      reset_req <= bridge_wr & (hit_reset | hit_boot);

      if (bridge_wr && hit_boot) begin
        boot_settings <= bridge_wr_data;
      end
      if (bridge_wr && hit_run) begin
        run_settings <= bridge_wr_data;
      end

      // read-back holds until the next read strobe
      if (bridge_rd) begin
        if (hit_boot) begin
          bridge_rd_data <= boot_settings;
        end else if (hit_run) begin
          bridge_rd_data <= run_settings;
        end else begin
          bridge_rd_data <= '0;
        end
      end
    end
  end

  // request is a single-cycle pulse into the reset timer
  a_reset_req_pulse: assert property (
    @(posedge clk_sys) disable iff (reset)
    reset_req |=> !reset_req
  );

endmodule

`default_nettype wire

/* hdl/reset_timer.sv */
`default_nettype none

`include "core_config.svh"

module reset_timer (
  input  wire  clk_sys,
  input  wire  reset,
  input  wire  reset_req,
  output logic core_reset
);

  localparam int CNT_W = $clog2(`CORE_RESET_CYCLES + 1);

  logic [CNT_W-1:0] count;

  // reload on every request, so a late request restarts the window
  always_ff @(posedge clk_sys) begin
    if (reset) begin
      count <= '0;
    end else if (reset_req) begin
      count <= CNT_W'(`CORE_RESET_CYCLES);
    end else if (count != '0) begin
      count <= count - 1'b1;
    end
  end

  assign core_reset = (count != '0);

  // core reset must follow every request immediately
  a_req_starts_reset: assert property (
    @(posedge clk_sys) disable iff (reset)
    reset_req |=> core_reset
  );

endmodule

`default_nettype wire

/* hdl/palette_loader.sv */
`default_nettype none

`include "core_config.svh"

module palette_loader
  import core_pkg::*;
(
  input  wire          clk_sys,
  input  wire          reset,
  input  wire          dataslot_requestwrite,
  input  wire  [15:0]  dataslot_requestwrite_id,
  input  wire          dataslot_allcomplete,
  input  wire          ioctl_wr,
  input  wire  [15:0]  ioctl_dout,
  output palette_t     palette,
  output logic         download_active
);

  logic palette_slot;
  logic palette_wr;

  // only the palette slot feeds the shift register
  assign palette_slot = (dataslot_requestwrite_id == slot_palette);
  assign palette_wr   = download_active & palette_slot & ioctl_wr;

  //////////////////////////////////////////////////
  // download tracking
  //////////////////////////////////////////////////

  always_ff @(posedge clk_sys) begin
    if (reset) begin
      download_active <= 1'b0;
    end else if (dataslot_requestwrite) begin
      download_active <= 1'b1;
    end else if (dataslot_allcomplete) begin
      download_active <= 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // palette shift
  //////////////////////////////////////////////////

  // loader words arrive byte-swapped relative to the palette file
  always_ff @(posedge clk_sys) begin
    if (reset) begin
      palette <= `PALETTE_DEFAULT;
    end else if (palette_wr) begin
      palette <= {palette[111:0], ioctl_dout[7:0], ioctl_dout[15:8]};
    end
  end

endmodule

`default_nettype wire

/* hdl/ff_control.sv */
`default_nettype none

`include "core_config.svh"

module ff_control
  import core_pkg::*;
(
  input  wire            clk_sys,
  input  wire            reset,
  input  wire  [31:0]    cont1_key,
  input  run_settings_t  run_settings,
  input  wire            download_active,
  output logic           fast_forward
);

  localparam int CNT_W = $clog2(`FF_TAP_CYCLES + 1);

  ff_state_e        state;
  logic             press;
  logic             press_q;
  logic             held;
  logic             tap_short;
  logic [CNT_W-1:0] hold_cnt;

  // button only counts when enabled and no download is running
  assign press = run_settings.ff_en & cont1_key[`FF_BUTTON_BIT] & ~download_active;

  assign held      = (state == ff_held) || (state == ff_latched_held);
  assign tap_short = (hold_cnt < CNT_W'(`FF_TAP_CYCLES));

  always_ff @(posedge clk_sys) begin
    if (reset) begin
      press_q      <= 1'b0;
      state        <= ff_idle;
      hold_cnt     <= '0;
      fast_forward <= 1'b0;
    end else begin
      press_q      <= press;
      fast_forward <= press_q | (state == ff_latched);

      case (state)
        ff_idle: begin
          if (press_q) begin
            hold_cnt <= '0;
            state    <= ff_held;
          end
        end
        // pressing again drops the latch
        ff_latched: begin
          if (press_q) begin
            hold_cnt <= '0;
            state    <= ff_latched_held;
          end
        end
        // release: short tap latches, long hold does not
        ff_held: begin
          if (!press_q) begin
            state <= tap_short ? ff_latched : ff_idle;
          end
        end
        // previous release latched, so this one unlatches
        ff_latched_held: begin
          if (!press_q) begin
            state <= ff_idle;
          end
        end
        default: begin
          state <= ff_idle;
        end
      endcase

      // saturates at the tap threshold
      if (held && press_q && tap_short) begin
        hold_cnt <= hold_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/video_sync.sv */
`default_nettype none

`include "core_config.svh"

module video_sync
  import core_pkg::*;
(
  input  wire          clk_sys,
  input  wire          reset,
  input  core_pixel_t  lcd_pixel,
  output video_out_t   sync_out
);

  localparam int HS_CNT_W = $clog2(`HS_DELAY_CYCLES + 2);

  logic                de_next;
  logic                hs_prev;
  logic                vs_prev;
  logic                hs_rise;
  logic                vs_rise;
  logic                de_q;
  logic                hs_q;
  logic                vs_q;
  logic [23:0]         rgb_q;
  logic [HS_CNT_W-1:0] hs_cnt;

  assign de_next = ~(lcd_pixel.hblank | lcd_pixel.vblank);
  assign hs_rise = lcd_pixel.hs & ~hs_prev;
  assign vs_rise = lcd_pixel.vs & ~vs_prev;

  // colour is blanked outside the active area
  always_ff @(posedge clk_sys) begin
    rgb_q <= de_next ? lcd_pixel.rgb : 24'h0;
  end

  always_ff @(posedge clk_sys) begin
    if (reset) begin
      de_q    <= 1'b0;
      hs_q    <= 1'b0;
      vs_q    <= 1'b0;
      hs_prev <= 1'b0;
      vs_prev <= 1'b0;
      hs_cnt  <= '0;
    end else begin
      de_q    <= de_next;
      hs_prev <= lcd_pixel.hs;
      vs_prev <= lcd_pixel.vs;

      // vs becomes a single pulse right after its edge
      vs_q <= vs_rise;

      // hs is pushed back to keep it clear of vs
      hs_q <= (hs_cnt == HS_CNT_W'(1));
      if (hs_rise) begin
        hs_cnt <= HS_CNT_W'(`HS_DELAY_CYCLES + 1);
      end else if (hs_cnt != '0) begin
        hs_cnt <= hs_cnt - 1'b1;
      end
    end
  end

  assign sync_out = '{rgb: rgb_q, de: de_q, hs: hs_q, vs: vs_q};

  a_no_hs_vs_overlap: assert property (
    @(posedge clk_sys) disable iff (reset)
    !(sync_out.hs && sync_out.vs)
  );

endmodule

`default_nettype wire

/* hdl/video_color.sv */
`default_nettype none

`include "core_config.svh"

module video_color
  import core_pkg::*;
(
  input  video_out_t      sync_out,
  input  boot_settings_t  boot_settings,
  input  run_settings_t   run_settings,
  input  wire             bw_en,
  output video_out_t      video
);

  logic [7:0] red;
  logic [7:0] green;
  logic [7:0] blue;
  logic [7:0] lum;
  logic       border_on;

  assign red   = sync_out.rgb[23:16];
  assign green = sync_out.rgb[15:8];
  assign blue  = sync_out.rgb[7:0];

  // approx 0.28 r + 0.56 g + 0.09 b, max 234 so no wrap
  assign lum = (red >> 2) + (red >> 5)
             + (green >> 1) + (green >> 4)
             + (blue >> 4) + (blue >> 5);

  // border only shown with the super mode enabled at boot
  assign border_on = run_settings.sgb_border_en & boot_settings.sgb_en;

  always_comb begin
    video = sync_out;
    if (!sync_out.de) begin
      video.rgb = border_on ? `BORDER_RGB : 24'h0;
    end else if (bw_en) begin
      video.rgb = {lum, lum, lum};
    end
  end

endmodule

`default_nettype wire

/* hdl/core_top.sv */
`default_nettype none

module core_top
  import core_pkg::*;
(
  input  wire          clk_sys,
  input  wire          reset,

  // bridge
  input  wire  [31:0]  bridge_addr,
  input  wire          bridge_rd,
  input  wire          bridge_wr,
  input  wire  [31:0]  bridge_wr_data,
  output logic [31:0]  bridge_rd_data,
  input  wire          bw_en,

  // slot downloads
  input  wire          dataslot_requestwrite,
  input  wire  [15:0]  dataslot_requestwrite_id,
  input  wire          dataslot_allcomplete,
  input  wire          ioctl_wr,
  input  wire  [15:0]  ioctl_dout,

  // player 1 only
  input  wire  [31:0]  cont1_key,

  input  core_pixel_t  lcd_pixel,

  output logic         core_reset,
  output logic         fast_forward,
  output palette_t     palette,
  output video_out_t   video
);

  boot_settings_t boot_settings;
  run_settings_t  run_settings;
  logic           reset_req;
  logic           download_active;
  video_out_t     sync_out;

  //////////////////////////////////////////////////
  // settings and core reset
  //////////////////////////////////////////////////

  bridge_regs bridge_regs_i (
    .clk_sys        (clk_sys),
    .reset          (reset),
    .bridge_addr    (bridge_addr),
    .bridge_rd      (bridge_rd),
    .bridge_wr      (bridge_wr),
    .bridge_wr_data (bridge_wr_data),
    .bridge_rd_data (bridge_rd_data),
    .boot_settings  (boot_settings),
    .run_settings   (run_settings),
    .reset_req      (reset_req)
  );

  reset_timer reset_timer_i (
    .clk_sys    (clk_sys),
    .reset      (reset),
    .reset_req  (reset_req),
    .core_reset (core_reset)
  );

  //////////////////////////////////////////////////
  // downloads and fast-forward
  //////////////////////////////////////////////////

  palette_loader palette_loader_i (
    .clk_sys                  (clk_sys),
    .reset                    (reset),
    .dataslot_requestwrite    (dataslot_requestwrite),
    .dataslot_requestwrite_id (dataslot_requestwrite_id),
    .dataslot_allcomplete     (dataslot_allcomplete),
    .ioctl_wr                 (ioctl_wr),
    .ioctl_dout               (ioctl_dout),
    .palette                  (palette),
    .download_active          (download_active)
  );

  ff_control ff_control_i (
    .clk_sys         (clk_sys),
    .reset           (reset),
    .cont1_key       (cont1_key),
    .run_settings    (run_settings),
    .download_active (download_active),
    .fast_forward    (fast_forward)
  );

  //////////////////////////////////////////////////
  // video out
  //////////////////////////////////////////////////

  video_sync video_sync_i (
    .clk_sys   (clk_sys),
    .reset     (reset),
    .lcd_pixel (lcd_pixel),
    .sync_out  (sync_out)
  );

  video_color video_color_i (
    .sync_out      (sync_out),
    .boot_settings (boot_settings),
    .run_settings  (run_settings),
    .bw_en         (bw_en),
    .video         (video)
  );

endmodule

`default_nettype wire

/* verif/core_top_tb.sv */
`default_nettype none

`include "core_config.svh"

module core_top_tb
  import core_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int hs_taps = `HS_DELAY_CYCLES + 2;
  localparam int tap_len = `FF_TAP_CYCLES / 8;
  localparam int long_len = `FF_TAP_CYCLES + 100;
  // reset window, tap tests and 2000 video cycles, plus margin
  localparam int timeout_cycles = `CORE_RESET_CYCLES + 2000 + 8 * `FF_TAP_CYCLES + 500;

  logic        clk_sys = 1'b0;
  logic        reset;
  logic [31:0] bridge_addr;
  logic        bridge_rd;
  logic        bridge_wr;
  logic [31:0] bridge_wr_data;
  logic [31:0] bridge_rd_data;
  logic        bw_en;
  logic        dataslot_requestwrite;
  logic [15:0] dataslot_requestwrite_id;
  logic        dataslot_allcomplete;
  logic        ioctl_wr;
  logic [15:0] ioctl_dout;
  logic [31:0] cont1_key;
  core_pixel_t lcd_pixel;
  logic        core_reset;
  logic        fast_forward;
  palette_t    palette;
  video_out_t  video;

  // reference model state
  boot_settings_t       m_boot;
  run_settings_t        m_run;
  logic [31:0]          m_rd_data;
  logic                 m_req;
  int                   m_cnt;
  logic                 m_dl;
  palette_t             m_palette;
  logic                 m_press_q;
  logic                 m_held;
  logic                 m_latch;
  logic                 m_last_set;
  logic                 m_ff;
  int                   m_hold;
  logic                 m_de;
  logic [23:0]          m_rgb;
  logic                 m_hs_prev;
  logic                 m_vs_prev;
  logic                 m_vs;
  logic [hs_taps-1:0]   m_hs_pipe;
  video_out_t           exp_video;

  int   errors = 0;
  int   cycle_count = 0;
  logic timed_out = 1'b0;

  core_top core_top_i (
    .clk_sys                  (clk_sys),
    .reset                    (reset),
    .bridge_addr              (bridge_addr),
    .bridge_rd                (bridge_rd),
    .bridge_wr                (bridge_wr),
    .bridge_wr_data           (bridge_wr_data),
    .bridge_rd_data           (bridge_rd_data),
    .bw_en                    (bw_en),
    .dataslot_requestwrite    (dataslot_requestwrite),
    .dataslot_requestwrite_id (dataslot_requestwrite_id),
    .dataslot_allcomplete     (dataslot_allcomplete),
    .ioctl_wr                 (ioctl_wr),
    .ioctl_dout               (ioctl_dout),
    .cont1_key                (cont1_key),
    .lcd_pixel                (lcd_pixel),
    .core_reset               (core_reset),
    .fast_forward             (fast_forward),
    .palette                  (palette),
    .video                    (video)
  );

  always #50 clk_sys = ~clk_sys;

  //////////////////////////////////////////////////
  // reference functions
  //////////////////////////////////////////////////

  function automatic logic [7:0] exp_lum(input logic [23:0] rgb);
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
    int         sum;
    r = rgb[23:16];
    g = rgb[15:8];
    b = rgb[7:0];
    sum = r / 4 + r / 32 + g / 2 + g / 16 + b / 16 + b / 32;
    return sum[7:0];
  endfunction

  function automatic logic [23:0] exp_rgb(input logic de, input logic [23:0] rgb,
                                          input boot_settings_t boot,
                                          input run_settings_t run, input logic bw);
    logic [7:0] lum;
    lum = exp_lum(rgb);
    if (!de) begin
      return (run.sgb_border_en && boot.sgb_en) ? `BORDER_RGB : 24'h0;
    end else if (bw) begin
      return {lum, lum, lum};
    end
    return rgb;
  endfunction

  // new word enters at the bottom, low byte first
  function automatic palette_t exp_palette(input palette_t pal, input logic [15:0] word);
    return (pal << 16) | palette_t'({word[7:0], word[15:8]});
  endfunction

  function automatic logic ff_pressed(input run_settings_t run, input logic [31:0] keys,
                                      input logic dl);
    return run.ff_en & keys[`FF_BUTTON_BIT] & ~dl;
  endfunction

  //////////////////////////////////////////////////
  // cycle model, updated on the same edge as the DUT
  //////////////////////////////////////////////////

  always @(posedge clk_sys) begin
    if (reset) begin
      m_boot     <= '0;
      m_run      <= '0;
      m_rd_data  <= '0;
      m_req      <= 1'b0;
      m_cnt      <= 0;
      m_dl       <= 1'b0;
      m_palette  <= `PALETTE_DEFAULT;
      m_press_q  <= 1'b0;
      m_held     <= 1'b0;
      m_latch    <= 1'b0;
      m_last_set <= 1'b0;
      m_ff       <= 1'b0;
      m_hold     <= 0;
      m_de       <= 1'b0;
      m_rgb      <= '0;
      m_hs_prev  <= 1'b0;
      m_vs_prev  <= 1'b0;
      m_vs       <= 1'b0;
      m_hs_pipe  <= '0;
    end else begin
      if (bridge_wr && bridge_addr == `CORE_ADDR_BOOT) begin
        m_boot <= bridge_wr_data;
      end
      if (bridge_wr && bridge_addr == `CORE_ADDR_RUN) begin
        m_run <= bridge_wr_data;
      end
      if (bridge_rd) begin
        if (bridge_addr == `CORE_ADDR_BOOT) begin
          m_rd_data <= m_boot;
        end else if (bridge_addr == `CORE_ADDR_RUN) begin
          m_rd_data <= m_run;
        end else begin
          m_rd_data <= '0;
        end
      end
      m_req <= bridge_wr && (bridge_addr == `CORE_ADDR_RESET ||
                             bridge_addr == `CORE_ADDR_BOOT);
      if (m_req) begin
        m_cnt <= `CORE_RESET_CYCLES;
      end else if (m_cnt > 0) begin
        m_cnt <= m_cnt - 1;
      end

      if (dataslot_requestwrite) begin
        m_dl <= 1'b1;
      end else if (dataslot_allcomplete) begin
        m_dl <= 1'b0;
      end
      if (m_dl && dataslot_requestwrite_id == slot_palette && ioctl_wr) begin
        m_palette <= exp_palette(m_palette, ioctl_dout);
      end

      // fast-forward, two cycles behind the button
      m_press_q <= ff_pressed(m_run, cont1_key, m_dl);
      m_ff      <= m_press_q | m_latch;
      if (m_press_q && !m_held) begin
        m_held  <= 1'b1;
        m_latch <= 1'b0;
        m_hold  <= 0;
      end else if (m_press_q) begin
        if (m_hold < `FF_TAP_CYCLES) begin
          m_hold <= m_hold + 1;
        end
      end else if (m_held) begin
        m_held <= 1'b0;
        if (m_hold < `FF_TAP_CYCLES && !m_last_set) begin
          m_latch    <= 1'b1;
          m_last_set <= 1'b1;
        end else begin
          m_last_set <= 1'b0;
        end
      end

      m_de      <= !(lcd_pixel.hblank || lcd_pixel.vblank);
      m_rgb     <= (lcd_pixel.hblank || lcd_pixel.vblank) ? 24'h0 : lcd_pixel.rgb;
      m_hs_prev <= lcd_pixel.hs;
      m_vs_prev <= lcd_pixel.vs;
      m_vs      <= lcd_pixel.vs & ~m_vs_prev;
      m_hs_pipe <= {m_hs_pipe[hs_taps-2:0], lcd_pixel.hs & ~m_hs_prev};
    end
  end

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] want);
    assert (got === want) else begin
      errors++;
      $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, want);
    end
  endtask

  // compare mid-cycle, away from both edges
  always @(negedge clk_sys) begin
    if (!reset) begin
      exp_video.rgb = exp_rgb(m_de, m_rgb, m_boot, m_run, bw_en);
      exp_video.de  = m_de;
      exp_video.hs  = m_hs_pipe[hs_taps-1];
      exp_video.vs  = m_vs;
      check_value("bridge_rd_data", 128'(bridge_rd_data), 128'(m_rd_data));
      check_value("core_reset", 128'(core_reset), 128'(m_cnt != 0));
      check_value("palette", 128'(palette), 128'(m_palette));
      check_value("fast_forward", 128'(fast_forward), 128'(m_ff));
      check_value("video", 128'(video), 128'(exp_video));
    end
  end

  //////////////////////////////////////////////////
  // stimulus tasks
  //////////////////////////////////////////////////

  task automatic next_cycle();
    @(posedge clk_sys);
    #10;
  endtask

  task automatic bridge_write(input logic [31:0] addr, input logic [31:0] data);
    bridge_addr    = addr;
    bridge_wr_data = data;
    bridge_wr      = 1'b1;
    next_cycle();
    bridge_wr = 1'b0;
  endtask

  task automatic bridge_read_check(input logic [31:0] addr, input logic [31:0] want);
    bridge_addr = addr;
    bridge_rd   = 1'b1;
    next_cycle();
    bridge_rd = 1'b0;
    @(negedge clk_sys);
    check_value("bridge_rd_data", 128'(bridge_rd_data), 128'(want));
    next_cycle();
  endtask

  task automatic download_start(input logic [15:0] id);
    dataslot_requestwrite_id = id;
    dataslot_requestwrite    = 1'b1;
    next_cycle();
    dataslot_requestwrite = 1'b0;
  endtask

  task automatic download_end();
    ioctl_wr             = 1'b0;
    dataslot_allcomplete = 1'b1;
    next_cycle();
    dataslot_allcomplete = 1'b0;
  endtask

  task automatic press_button(input int cycles, input logic want_held);
    cont1_key[`FF_BUTTON_BIT] = 1'b1;
    repeat (cycles) next_cycle();
    @(negedge clk_sys);
    check_value("fast_forward", 128'(fast_forward), 128'(want_held));
    next_cycle();
    cont1_key[`FF_BUTTON_BIT] = 1'b0;
    repeat (10) next_cycle();
  endtask

  task automatic expect_ff(input logic want);
    @(negedge clk_sys);
    check_value("fast_forward", 128'(fast_forward), 128'(want));
    next_cycle();
  endtask

  //////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////

  task automatic test_core_reset();
    int wait_cnt;
    int high_cnt;
    // the cycle that carries the write counts as the first one
    wait_cnt = 1;
    high_cnt = 0;
    bridge_write(`CORE_ADDR_RESET, 32'h0);
    @(negedge clk_sys);
    while (!core_reset) begin
      wait_cnt++;
      @(negedge clk_sys);
    end
    while (core_reset) begin
      high_cnt++;
      @(negedge clk_sys);
    end
    check_value("core_reset delay", 128'(wait_cnt), 128'(2));
    check_value("core_reset length", 128'(high_cnt), 128'(`CORE_RESET_CYCLES));
    next_cycle();
    // run word carries no reset request
    bridge_write(`CORE_ADDR_RUN, 32'h0);
    repeat (20) begin
      @(negedge clk_sys);
      check_value("core_reset", 128'(core_reset), 128'(0));
    end
    next_cycle();
  endtask

  task automatic test_settings();
    logic [31:0] boot_word;
    logic [31:0] run_word;
    logic [31:0] other;
    for (int i = 0; i < 4; i++) begin
      boot_word = $urandom;
      run_word  = $urandom;
      other     = $urandom & 32'h0FFF_FFFF;
      bridge_write(`CORE_ADDR_BOOT, boot_word);
      bridge_write(`CORE_ADDR_RUN, run_word);
      bridge_read_check(`CORE_ADDR_BOOT, boot_word);
      bridge_read_check(`CORE_ADDR_RUN, run_word);
      bridge_read_check(other, 32'h0);
    end
    bridge_read_check(`CORE_ADDR_RESET, 32'h0);
  endtask

  task automatic test_palette();
    palette_t    ref_pal;
    logic [31:0] word;
    ref_pal = `PALETTE_DEFAULT;
    @(negedge clk_sys);
    check_value("palette", 128'(palette), 128'(ref_pal));
    next_cycle();
    download_start(slot_palette);
    for (int i = 0; i < 12; i++) begin
      word       = $urandom;
      ioctl_dout = word[15:0];
      ioctl_wr   = word[16];
      if (word[16]) begin
        ref_pal = exp_palette(ref_pal, word[15:0]);
      end
      next_cycle();
    end
    download_end();
    // another slot must leave the palette alone
    download_start(slot_border);
    for (int i = 0; i < 8; i++) begin
      word       = $urandom;
      ioctl_dout = word[15:0];
      ioctl_wr   = 1'b1;
      next_cycle();
    end
    download_end();
    @(negedge clk_sys);
    check_value("palette", 128'(palette), 128'(ref_pal));
    next_cycle();
  endtask

  task automatic test_fast_forward();
    bridge_write(`CORE_ADDR_RUN, 32'h8);
    press_button(long_len, 1'b1);
    expect_ff(1'b0);
    press_button(tap_len, 1'b1);
    expect_ff(1'b1);
    press_button(tap_len, 1'b1);
    expect_ff(1'b0);
    press_button(long_len, 1'b1);
    expect_ff(1'b0);
    // disabled
    bridge_write(`CORE_ADDR_RUN, 32'h0);
    press_button(tap_len, 1'b0);
    expect_ff(1'b0);
    // blocked while a download runs
    bridge_write(`CORE_ADDR_RUN, 32'h8);
    download_start(slot_border);
    press_button(tap_len, 1'b0);
    download_end();
    expect_ff(1'b0);
  endtask

  // 5 frames of 10 lines by 40 pixels, settings change per frame
  task automatic test_video();
    logic [31:0] word;
    int          frame;
    for (int line = 0; line < 50; line++) begin
      word  = $urandom;
      bw_en = word[0];
      frame = line / 10;
      for (int c = 0; c < 40; c++) begin
        word             = $urandom;
        lcd_pixel.rgb    = word[23:0];
        lcd_pixel.hs     = (c < 4);
        lcd_pixel.hblank = (c < 8);
        lcd_pixel.vblank = (line % 10 < 2);
        lcd_pixel.vs     = (line % 10 == 0) && (c >= 20);
        bridge_wr        = 1'b0;
        if (line % 10 == 0 && c < 2) begin
          word        = $urandom;
          bridge_addr = (c == 0) ? `CORE_ADDR_RUN : `CORE_ADDR_BOOT;
          // border enables step through all four combinations
          bridge_wr_data = (c == 0) ? {word[31:5], frame[0], word[3:0]}
                                    : {word[31:1], frame[1]};
          bridge_wr      = 1'b1;
        end
        next_cycle();
      end
    end
    bridge_wr = 1'b0;
  endtask

  task automatic run_tests();
    repeat (8) @(posedge clk_sys);
    #10;
    reset = 1'b0;
    test_core_reset();
    test_settings();
    test_palette();
    test_fast_forward();
    test_video();
  endtask

  initial begin
    void'($urandom(32'h547fa35c));
    reset                    = 1'b1;
    bridge_addr              = '0;
    bridge_rd                = 1'b0;
    bridge_wr                = 1'b0;
    bridge_wr_data           = '0;
    bw_en                    = 1'b0;
    dataslot_requestwrite    = 1'b0;
    dataslot_requestwrite_id = '0;
    dataslot_allcomplete     = 1'b0;
    ioctl_wr                 = 1'b0;
    ioctl_dout               = '0;
    cont1_key                = '0;
    lcd_pixel                = '0;

    fork
      run_tests();
      begin
        while (cycle_count < timeout_cycles) begin
          @(posedge clk_sys);
          cycle_count++;
        end
        timed_out = 1'b1;
      end
    join_any
    disable fork;

    if (timed_out) begin
      $display("Timeout: tests did not complete within %0d cycles", timeout_cycles);
    end
    $display("Checks complete with %0d errors", errors);
    if (!timed_out && errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+hdl
hdl/core_pkg.sv
hdl/bridge_regs.sv
hdl/reset_timer.sv
hdl/palette_loader.sv
hdl/ff_control.sv
hdl/video_sync.sv
hdl/video_color.sv
hdl/core_top.sv
verif/core_top_tb.sv
